//--- tspi_cfg.svh
////////////////////
// TSPI response checker configuration
// Widths, command word offsets and byte-count
// constants shared by RTL and testbench
////////////////////

`ifndef TSPI_CFG_SVH
`define TSPI_CFG_SVH

// Datapath widths
`define TSPI_DATA_W 32
`define TSPI_ADDR_W 8
`define TSPI_CNT_W  8
`define TSPI_LEN_W  6
`define TSPI_ID_W   5

// Command word offsets
`define TSPI_OFF_BEGINNING       8'd0
`define TSPI_OFF_BUFFER          8'd1
`define TSPI_OFF_CHANGE_BAUDRATE 8'd2
`define TSPI_OFF_CMD0            8'd3
`define TSPI_OFF_CMD8            8'd4
`define TSPI_OFF_CMD59           8'd5
`define TSPI_OFF_CMD58           8'd6
`define TSPI_OFF_ACMD41          8'd7

// Top of the single-word transparent range
`define TSPI_OFF_RW_MAX 8'd63

// Write transfer byte counts
`define TSPI_CNT_WR_TOKEN     8'd198
`define TSPI_CNT_WR_DATA_RESP 8'd68

// Read transfer byte counts
`define TSPI_CNT_RD_TOKEN 8'd130
`define TSPI_CNT_RD_CRC   8'd129
`define TSPI_CNT_RD_LAST  8'd128

`endif

//--- hdl/tspi_pkg.sv
////////////////////
// TSPI response checker types
// Vector typedefs for the bus and shift register
// fields, and the response-type encoding
////////////////////

`include "tspi_cfg.svh"

package tspi_pkg;

    // Shift-register word, compare value and mask
    typedef logic [`TSPI_DATA_W-1:0] tspi_word_t;

    // Command word offset on the bus
    typedef logic [`TSPI_ADDR_W-1:0] tspi_addr_t;

    // Byte counter of the running command
    typedef logic [`TSPI_CNT_W-1:0] tspi_cnt_t;

    // Response length in bits, minus one
    typedef logic [`TSPI_LEN_W-1:0] tspi_len_t;

    // Bus transaction ID
    typedef logic [`TSPI_ID_W-1:0] tspi_id_t;

    ////////////////////
    // Response types
    ////////////////////

    // How a received frame is judged at its end
    typedef enum logic [2:0] {
        PASSTHROUGH      = 3'd0,
        VALIDATE         = 3'd1,
        ERROR            = 3'd2,
        FINAL            = 3'd3,
        CAUSE_ERROR      = 3'd4,
        CAUSE_VALIDATION = 3'd5,
        CHECK_IF_DATA    = 3'd6
    } resp_type_t;

endpackage

//--- hdl/tspi_cmd_decode.sv
////////////////////
// TSPI command decoder
// Maps the addressed command and byte count to a response
// type, compare value and mask. The type is registered on
// each rising edge of the serial clock.
////////////////////

`timescale 1ns/1ns

`include "tspi_cfg.svh"

module tspi_cmd_decode (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   tspi_clk_i,
    input  logic                   req_i,
    input  logic                   we_i,
    input  tspi_pkg::tspi_addr_t   addr_i,
    input  tspi_pkg::tspi_cnt_t    cnt_cmd_i,
    input  tspi_pkg::tspi_len_t    len_cmd_i,
    output tspi_pkg::resp_type_t   resp_type_o,
    output tspi_pkg::tspi_word_t   compare_data_o,
    output tspi_pkg::tspi_word_t   compare_mask_o
);

    import tspi_pkg::*;

    resp_type_t resp_type_d;
    resp_type_t resp_type_q;
    tspi_word_t default_mask;
    tspi_word_t base_mask;
    tspi_word_t care_mask;
    logic       tspi_clk_q;
    logic       tspi_edge;

    // Low len_cmd+1 bits set
    assign default_mask = ~({{(`TSPI_DATA_W-1){1'b1}}, 1'b0} << len_cmd_i);

    ////////////////////
    // Command table
    ////////////////////

    always_comb begin
        resp_type_d    = PASSTHROUGH;
        compare_data_o = '0;
        base_mask      = default_mask;
        care_mask      = '1;

        case (addr_i)
            `TSPI_OFF_BEGINNING, `TSPI_OFF_BUFFER: begin
                if (cnt_cmd_i == 8'd1) begin
                    resp_type_d = VALIDATE;
                end
            end
            `TSPI_OFF_CHANGE_BAUDRATE: begin
                resp_type_d = we_i ? VALIDATE : ERROR;
            end
            `TSPI_OFF_CMD0, `TSPI_OFF_CMD59: begin
                // R1 idle bit expected
                resp_type_d    = FINAL;
                compare_data_o = 32'h0000_0001;
                care_mask      = 32'h0000_00FF;
            end
            `TSPI_OFF_CMD8: begin
                if (cnt_cmd_i == 8'd2) begin
                    resp_type_d    = CAUSE_ERROR;
                    compare_data_o = 32'h0100_0001;
                end else begin
                    // Echoed check pattern
                    resp_type_d    = FINAL;
                    compare_data_o = 32'h0000_00AA;
                    care_mask      = 32'h0000_00FF;
                end
            end
            `TSPI_OFF_CMD58: begin
                if (cnt_cmd_i == 8'd2) begin
                    resp_type_d    = CAUSE_ERROR;
                    compare_data_o = 32'h0100_FF80;
                    base_mask      = 32'hFF00_0000;
                end else begin
                    resp_type_d = VALIDATE;
                end
            end
            `TSPI_OFF_ACMD41: begin
                // Polled until the card leaves idle
                case (cnt_cmd_i[2:0])
                    3'd5: begin
                        resp_type_d = PASSTHROUGH;
                    end
                    3'd2: begin
                        resp_type_d    = CAUSE_VALIDATION;
                        compare_data_o = 32'hFFFF_FF00;
                    end
                    default: begin
                        if (cnt_cmd_i == 8'd1) begin
                            resp_type_d    = CAUSE_ERROR;
                            compare_data_o = 32'hFFFF_FF00;
                        end
                    end
                endcase
            end
            default: begin
                if (addr_i <= `TSPI_OFF_RW_MAX && req_i) begin
                    if (we_i) begin
                        // Transparent write
                        case (cnt_cmd_i)
                            `TSPI_CNT_WR_TOKEN: begin
                                resp_type_d    = CAUSE_ERROR;
                                compare_data_o = 32'hFFFF_FF00;
                            end
                            `TSPI_CNT_WR_DATA_RESP: begin
                                // Data response token, accepted = 0b00101
                                resp_type_d    = CAUSE_ERROR;
                                compare_data_o = 32'hFFFF_FF05;
                                base_mask      = 32'h0000_001F;
                            end
                            8'd1: begin
                                resp_type_d = ERROR;
                            end
                            default: begin
                                if (cnt_cmd_i > 8'd1 && cnt_cmd_i < `TSPI_CNT_WR_DATA_RESP) begin
                                    resp_type_d    = CAUSE_VALIDATION;
                                    compare_data_o = 32'hFFFF_FFFF;
                                    base_mask      = 32'h0000_0001;
                                end
                            end
                        endcase
                    end else begin
                        // Transparent read
                        case (cnt_cmd_i)
                            `TSPI_CNT_RD_TOKEN: begin
                                resp_type_d    = CAUSE_ERROR;
                                compare_data_o = 32'hFFFF_FF00;
                            end
                            `TSPI_CNT_RD_CRC, `TSPI_CNT_RD_LAST: begin
                                resp_type_d = PASSTHROUGH;
                            end
                            8'd1: begin
                                resp_type_d = ERROR;
                            end
                            default: begin
                                if (cnt_cmd_i > 8'd1 && cnt_cmd_i < `TSPI_CNT_RD_LAST) begin
                                    resp_type_d = CHECK_IF_DATA;
                                end
                            end
                        endcase
                    end
                end
            end
        endcase
    end

    assign compare_mask_o = base_mask & care_mask;

    ////////////////////
    // Serial clock edge and type register
    ////////////////////

    assign tspi_edge = tspi_clk_i & ~tspi_clk_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tspi_clk_q  <= 1'b0;
            resp_type_q <= PASSTHROUGH;
        end else begin
            tspi_clk_q <= tspi_clk_i;
            if (tspi_edge) begin
                resp_type_q <= resp_type_d;
            end
        end
    end

    assign resp_type_o = resp_type_q;

    // Value 3'd7 has no meaning
    a_resp_type_legal: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        resp_type_q inside {PASSTHROUGH, VALIDATE, ERROR, FINAL,
                            CAUSE_ERROR, CAUSE_VALIDATION, CHECK_IF_DATA}
    );

endmodule

//--- hdl/tspi_resp_verdict.sv
////////////////////
// TSPI response verdict
// Judges the shifted-in word at each frame end
// against the registered response type
////////////////////

`timescale 1ns/1ns

module tspi_resp_verdict (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  tspi_pkg::tspi_word_t data_i,
    input  tspi_pkg::resp_type_t resp_type_i,
    input  tspi_pkg::tspi_word_t compare_data_i,
    input  tspi_pkg::tspi_word_t compare_mask_i,
    input  logic                 en_write_i,
    input  logic                 last_bit_i,
    input  logic                 start_bit_i,
    output logic                 correct_o,
    output logic                 error_o
);

    import tspi_pkg::*;

    logic last_bit_q;
    logic data_seen_q;
    logic frame_end;
    logic match;

    ////////////////////
    // Frame tracking
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_bit_q  <= 1'b0;
            data_seen_q <= 1'b0;
        end else begin
            last_bit_q <= last_bit_i;
            // Start bit wins over a coincident last bit
            if (start_bit_i) begin
                data_seen_q <= 1'b1;
            end else if (last_bit_i) begin
                data_seen_q <= 1'b0;
            end
        end
    end

    // Rising last bit of a received frame
    assign frame_end = last_bit_i & ~last_bit_q & ~en_write_i;

    // Only the bits under the mask count
    assign match = ((data_i ^ compare_data_i) & compare_mask_i) == '0;

    ////////////////////
    // Verdict rules
    ////////////////////

    always_comb begin
        correct_o = 1'b0;
        error_o   = 1'b0;
        if (frame_end) begin
            case (resp_type_i)
                FINAL: begin
                    correct_o = match;
                    error_o   = ~match;
                end
                CAUSE_ERROR: begin
                    error_o = ~match;
                end
                CAUSE_VALIDATION: begin
                    correct_o = match;
                end
                VALIDATE: begin
                    correct_o = 1'b1;
                end
                ERROR: begin
                    error_o = 1'b1;
                end
                CHECK_IF_DATA: begin
                    correct_o = data_seen_q;
                end
                default: begin
                    correct_o = 1'b0;
                    error_o   = 1'b0;
                end
            endcase
        end
    end

    a_verdict_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(correct_o && error_o)
    );

endmodule

//--- hdl/tspi_bus_resp.sv
////////////////////
// TSPI bus response
// Turns a verdict into grant, valid, error and ID
////////////////////

`timescale 1ns/1ns

module tspi_bus_resp (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  tspi_pkg::tspi_id_t   aid_i,
    input  tspi_pkg::tspi_word_t data_i,
    input  logic                 correct_i,
    input  logic                 error_i,
    output logic                 gnt_o,
    output logic                 rvalid_o,
    output logic                 err_o,
    output tspi_pkg::tspi_id_t   rid_o,
    output tspi_pkg::tspi_word_t rdata_o,
    output logic                 done_o
);

    import tspi_pkg::*;

    logic     correct_q;
    logic     error_q;
    tspi_id_t id_q;

    // Request phase
    assign done_o = correct_i | error_i;
    assign gnt_o  = done_o | ~req_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            correct_q <= 1'b0;
            error_q   <= 1'b0;
        end else begin
            correct_q <= correct_i;
            error_q   <= error_i;
        end
    end

    always_ff @(posedge clk_i) begin
        id_q <= aid_i;
    end

    // Response phase, one cycle after the verdict
    assign rvalid_o = correct_q | error_q;
    assign err_o    = error_q;
    assign rid_o    = id_q;
    assign rdata_o  = data_i;

    a_rvalid_after_done: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rvalid_o |-> $past(done_o)
    );

endmodule

//--- hdl/tspi_resp_checker.sv
////////////////////
// TSPI response checker top
// Command decode, verdict and bus response
////////////////////

`timescale 1ns/1ns

module tspi_resp_checker (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 tspi_clk_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  tspi_pkg::tspi_addr_t addr_i,
    input  tspi_pkg::tspi_id_t   aid_i,
    input  tspi_pkg::tspi_word_t data_i,
    input  tspi_pkg::tspi_len_t  len_cmd_i,
    input  tspi_pkg::tspi_cnt_t  cnt_cmd_i,
    input  logic                 en_write_i,
    input  logic                 last_bit_i,
    input  logic                 start_bit_i,
    output logic                 gnt_o,
    output logic                 rvalid_o,
    output logic                 err_o,
    output tspi_pkg::tspi_id_t   rid_o,
    output tspi_pkg::tspi_word_t rdata_o,
    output logic                 done_o
);

    import tspi_pkg::*;

    resp_type_t resp_type;
    tspi_word_t compare_data;
    tspi_word_t compare_mask;
    logic       correct;
    logic       error;

    tspi_cmd_decode u_cmd_decode (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .tspi_clk_i     (tspi_clk_i),
        .req_i          (req_i),
        .we_i           (we_i),
        .addr_i         (addr_i),
        .cnt_cmd_i      (cnt_cmd_i),
        .len_cmd_i      (len_cmd_i),
        .resp_type_o    (resp_type),
        .compare_data_o (compare_data),
        .compare_mask_o (compare_mask)
    );

    tspi_resp_verdict u_resp_verdict (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .data_i         (data_i),
        .resp_type_i    (resp_type),
        .compare_data_i (compare_data),
        .compare_mask_i (compare_mask),
        .en_write_i     (en_write_i),
        .last_bit_i     (last_bit_i),
        .start_bit_i    (start_bit_i),
        .correct_o      (correct),
        .error_o        (error)
    );

    tspi_bus_resp u_bus_resp (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .aid_i     (aid_i),
        .data_i    (data_i),
        .correct_i (correct),
        .error_i   (error),
        .gnt_o     (gnt_o),
        .rvalid_o  (rvalid_o),
        .err_o     (err_o),
        .rid_o     (rid_o),
        .rdata_o   (rdata_o),
        .done_o    (done_o)
    );

endmodule

//--- testbench/tspi_vectors.svh
////////////////////
// TSPI response checker test vectors
// One entry per frame, applied in order by the testbench
////////////////////

`ifndef TSPI_VECTORS_SVH
`define TSPI_VECTORS_SVH

// Expected bus response of one frame
localparam logic [1:0] KIND_NONE = 2'd0;
localparam logic [1:0] KIND_OK   = 2'd1;
localparam logic [1:0] KIND_ERR  = 2'd2;

localparam int NUM_VEC = 24;

// rand_mask marks data bits that are outside the compare mask
typedef struct {
    tspi_addr_t addr;
    logic       we;
    logic       req;
    tspi_cnt_t  cnt_cmd;
    tspi_len_t  len_cmd;
    tspi_word_t data;
    tspi_word_t rand_mask;
    logic       en_write;
    logic       start_bit;
    logic [1:0] kind;
    tspi_id_t   aid;
} vec_t;

vec_t vec [NUM_VEC];

task automatic load_vectors();
    // Columns: addr, we, req, cnt, len, data, rand_mask, en_write, start, kind, aid
    vec[0]  = '{8'd3,   1'b0, 1'b1, 8'd1,   6'd7, 32'h0000_0001, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_OK,   5'd1};
    vec[1]  = '{8'd3,   1'b0, 1'b1, 8'd1,   6'd7, 32'h0000_0005, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_ERR,  5'd2};
    vec[2]  = '{8'd4,   1'b0, 1'b1, 8'd3,   6'd7, 32'h0000_00AA, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_OK,   5'd3};
    vec[3]  = '{8'd4,   1'b0, 1'b1, 8'd3,   6'd7, 32'h0000_00AB, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_ERR,  5'd4};
    vec[4]  = '{8'd5,   1'b0, 1'b1, 8'd1,   6'd7, 32'h0000_0001, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_OK,   5'd5};
    vec[5]  = '{8'd5,   1'b0, 1'b1, 8'd1,   6'd7, 32'h0000_0000, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_ERR,  5'd6};
    // CMD58 checks the top byte only
    vec[6]  = '{8'd6,   1'b0, 1'b1, 8'd2,   6'd7, 32'h0200_0000, 32'h00FF_FFFF, 1'b0, 1'b0, KIND_ERR,  5'd7};
    vec[7]  = '{8'd6,   1'b0, 1'b1, 8'd2,   6'd7, 32'h0100_0000, 32'h00FF_FFFF, 1'b0, 1'b0, KIND_NONE, 5'd8};
    vec[8]  = '{8'd7,   1'b0, 1'b1, 8'd2,   6'd7, 32'h0000_0000, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_OK,   5'd9};
    vec[9]  = '{8'd7,   1'b0, 1'b1, 8'd2,   6'd7, 32'h0000_003C, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_NONE, 5'd10};
    vec[10] = '{8'd8,   1'b1, 1'b1, 8'd68,  6'd7, 32'h0000_0006, 32'hFFFF_FFE0, 1'b0, 1'b0, KIND_ERR,  5'd11};
    vec[11] = '{8'd8,   1'b1, 1'b1, 8'd68,  6'd7, 32'h0000_0005, 32'hFFFF_FFE0, 1'b0, 1'b0, KIND_NONE, 5'd12};
    vec[12] = '{8'd1,   1'b0, 1'b1, 8'd1,   6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0, KIND_OK,   5'd13};
    vec[13] = '{8'd2,   1'b1, 1'b1, 8'd4,   6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0, KIND_OK,   5'd14};
    vec[14] = '{8'd2,   1'b0, 1'b1, 8'd4,   6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0, KIND_ERR,  5'd15};
    vec[15] = '{8'd20,  1'b0, 1'b1, 8'd1,   6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0, KIND_ERR,  5'd16};
    // Read data block, with and without a start bit
    vec[16] = '{8'd20,  1'b0, 1'b1, 8'd50,  6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b1, KIND_OK,   5'd17};
    vec[17] = '{8'd20,  1'b0, 1'b1, 8'd50,  6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0, KIND_NONE, 5'd18};
    vec[18] = '{8'd2,   1'b1, 1'b1, 8'd4,   6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b1, 1'b0, KIND_NONE, 5'd19};
    vec[19] = '{8'd7,   1'b0, 1'b1, 8'd5,   6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0, KIND_NONE, 5'd20};
    // CRC byte passes through even after a start bit
    vec[20] = '{8'd30,  1'b0, 1'b1, 8'd129, 6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b1, KIND_NONE, 5'd21};
    vec[21] = '{8'd100, 1'b1, 1'b1, 8'd1,   6'd7, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0, KIND_NONE, 5'd22};
    vec[22] = '{8'd7,   1'b0, 1'b1, 8'd1,   6'd7, 32'h0000_0017, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_ERR,  5'd23};
    vec[23] = '{8'd3,   1'b0, 1'b1, 8'd1,   6'd7, 32'h0000_0001, 32'hFFFF_FF00, 1'b0, 1'b0, KIND_OK,   5'd24};
endtask

`endif

//--- testbench/tb_tspi_resp_checker.sv
////////////////////
// TSPI response checker testbench
// Applies the vector table frame by frame and
// checks verdict, grant, ID and read data
////////////////////

`timescale 1ns/1ns

`include "tspi_cfg.svh"

module tb_tspi_resp_checker;

    import tspi_pkg::*;

    `include "tspi_vectors.svh"

    localparam int MAX_CYCLES = 400;

    logic       clk_i;
    logic       rst_n_i;
    logic       tspi_clk_i;
    logic       req_i;
    logic       we_i;
    tspi_addr_t addr_i;
    tspi_id_t   aid_i;
    tspi_word_t data_i;
    tspi_len_t  len_cmd_i;
    tspi_cnt_t  cnt_cmd_i;
    logic       en_write_i;
    logic       last_bit_i;
    logic       start_bit_i;
    logic       gnt_o;
    logic       rvalid_o;
    logic       err_o;
    tspi_id_t   rid_o;
    tspi_word_t rdata_o;
    logic       done_o;

    integer     seed;
    int         cycle_count;

    tspi_resp_checker u_tspi_resp_checker (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .tspi_clk_i  (tspi_clk_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .aid_i       (aid_i),
        .data_i      (data_i),
        .len_cmd_i   (len_cmd_i),
        .cnt_cmd_i   (cnt_cmd_i),
        .en_write_i  (en_write_i),
        .last_bit_i  (last_bit_i),
        .start_bit_i (start_bit_i),
        .gnt_o       (gnt_o),
        .rvalid_o    (rvalid_o),
        .err_o       (err_o),
        .rid_o       (rid_o),
        .rdata_o     (rdata_o),
        .done_o      (done_o)
    );

    always #10 clk_i = ~clk_i;

    ////////////////////
    // Failure reporting and checks
    ////////////////////

    task automatic stop_on_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_verdict(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s rvalid/err got %b expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_id(input tspi_id_t got, input tspi_id_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_word(input tspi_word_t got, input tspi_word_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // Run limit
    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            stop_on_failure();
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        tspi_word_t drv_data;
        logic [1:0] exp_pair;
        logic       exp_done;

        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        tspi_clk_i  = 1'b0;
        req_i       = 1'b0;
        we_i        = 1'b0;
        addr_i      = '0;
        aid_i       = '0;
        data_i      = '0;
        len_cmd_i   = '0;
        cnt_cmd_i   = '0;
        en_write_i  = 1'b0;
        last_bit_i  = 1'b0;
        start_bit_i = 1'b0;
        seed        = 32'hda31b29f;
        cycle_count = 0;
        load_vectors();

        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Idle bus after reset
        repeat (3) begin
            @(negedge clk_i);
            check_verdict({rvalid_o, err_o}, 2'b00, "idle");
            check_flag(done_o, 1'b0, "idle done_o");
            check_flag(gnt_o, 1'b1, "idle gnt_o");
        end

        for (int i = 0; i < NUM_VEC; i++) begin
            drv_data = (vec[i].data & ~vec[i].rand_mask) | ($random(seed) & vec[i].rand_mask);
            exp_done = (vec[i].kind != KIND_NONE);
            case (vec[i].kind)
                KIND_OK:  exp_pair = 2'b10;
                KIND_ERR: exp_pair = 2'b11;
                default:  exp_pair = 2'b00;
            endcase

            @(posedge clk_i);
            addr_i     <= vec[i].addr;
            we_i       <= vec[i].we;
            req_i      <= vec[i].req;
            cnt_cmd_i  <= vec[i].cnt_cmd;
            len_cmd_i  <= vec[i].len_cmd;
            data_i     <= drv_data;
            en_write_i <= vec[i].en_write;
            aid_i      <= vec[i].aid;
            @(posedge clk_i);
            tspi_clk_i <= 1'b1;
            @(posedge clk_i);
            tspi_clk_i <= 1'b0;
            @(posedge clk_i);
            start_bit_i <= vec[i].start_bit;
            @(posedge clk_i);
            start_bit_i <= 1'b0;
            last_bit_i  <= 1'b1;

            // Frame-end cycle
            @(negedge clk_i);
            check_flag(done_o, exp_done, $sformatf("entry %0d done_o", i));
            check_flag(gnt_o, exp_done || !vec[i].req, $sformatf("entry %0d gnt_o", i));
            check_word(rdata_o, drv_data, $sformatf("entry %0d rdata_o", i));

            // Response cycle, last bit still held
            @(posedge clk_i);
            @(negedge clk_i);
            check_verdict({rvalid_o, err_o}, exp_pair, $sformatf("entry %0d", i));
            check_id(rid_o, vec[i].aid, $sformatf("entry %0d rid_o", i));
            check_flag(done_o, 1'b0, $sformatf("entry %0d held last bit", i));

            @(posedge clk_i);
            last_bit_i <= 1'b0;
            @(negedge clk_i);
            check_verdict({rvalid_o, err_o}, 2'b00, $sformatf("entry %0d after response", i));
            @(posedge clk_i);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
+incdir+testbench
hdl/tspi_pkg.sv
hdl/tspi_cmd_decode.sv
hdl/tspi_resp_verdict.sv
hdl/tspi_bus_resp.sv
hdl/tspi_resp_checker.sv
testbench/tb_tspi_resp_checker.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator; exit status carries the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_tspi_resp_checker -Mdir obj_dir \
    && ./obj_dir/Vtb_tspi_resp_checker \
    || exit 1
